// ==== flist.f ====
dtw_pkg.sv
dtw_ifs.sv
stream_filter.sv
sample_fifo.sv
ref_loader.sv
reg_block.sv
dtw_accel_top.sv
tb_dtw_accel.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the dtw accelerator testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_dtw_accel -f flist.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "verilator build or simulation run did not complete"; exit 1; }
cat sim.log
[ -s sim.log ] || { echo "simulation log is empty"; exit 1; }
grep -q "Some tests failed" sim.log && exit 1 || exit 0

// ==== tb_dtw_accel.sv ====
//******************************
// dtw accelerator testbench
// directed tests of registers, stream and loader
//******************************
`timescale 1ns/100ps

module tb_dtw_accel
    import dtw_pkg::*;
();

    // test length stays well under this
    localparam int CYCLE_LIMIT = 3000;
    localparam logic [DEST_WIDTH-1:0] MY_DEST = 4'd3;

    logic                      S_AXI_clk;
    logic                      w_axi_rst;
    logic [REG_ADDR_WIDTH-1:0] i_reg_addr;
    logic [DATA_WIDTH-1:0]     i_reg_wdata;
    logic                      i_reg_wr;
    logic                      i_reg_rd;
    logic                      o_reg_ack;
    logic [DATA_WIDTH-1:0]     o_reg_rdata;
    logic                      o_reg_invalid;
    logic [DATA_WIDTH-1:0]     i_src_tdata;
    logic [DEST_WIDTH-1:0]     i_src_tdest;
    logic                      i_src_tvalid;
    logic                      o_src_tready;

    logic [15:0]             lfsr_q;
    // samples that should land in reference memory, in order
    logic [SAMPLE_WIDTH-1:0] exp_q[$];
    int cycles;
    int checks;
    int errors;
    int tests_run;
    int tests_bad;

    dtw_accel_top #(.FIFO_DEPTH(4), .CHANNEL_ID(3)) i_dtw_accel_top (.*);

    initial S_AXI_clk = 1'b0;
    always #50 S_AXI_clk = ~S_AXI_clk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_word(output logic [DATA_WIDTH-1:0] w);
        w = '0;
        for (int k = 0; k < DATA_WIDTH; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w = {w[DATA_WIDTH-2:0], lfsr_q[0]};
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
            tests_bad++;
        end
    endtask

    // one strobe, then wait for the ack
    task automatic reg_access(input logic wr, input logic [REG_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic inval);
        int n;
        @(posedge S_AXI_clk);
        i_reg_wr    <= wr;
        i_reg_rd    <= ~wr;
        i_reg_addr  <= addr;
        i_reg_wdata <= wdata;
        @(posedge S_AXI_clk);
        i_reg_wr <= 1'b0;
        i_reg_rd <= 1'b0;
        n = 0;
        @(negedge S_AXI_clk);
        while (!o_reg_ack && n < 10) begin
            @(negedge S_AXI_clk);
            n++;
        end
        if (!o_reg_ack) begin
            $display("register access to address %0d was never acknowledged", addr);
            errors++;
        end
        rdata = o_reg_rdata;
        inval = o_reg_invalid;
    endtask

    task automatic write_reg(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        logic [31:0] d;
        logic        inv;
        reg_access(1'b1, addr, data, d, inv);
        check("o_reg_invalid", 32'(inv), 32'h0);
    endtask

    task automatic read_reg(input logic [REG_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        logic inv;
        reg_access(1'b0, addr, 32'h0, data, inv);
        check("o_reg_invalid", 32'(inv), 32'h0);
    endtask

    // pulse soft_rst, leaves run clear
    task automatic soft_reset();
        write_reg(REG_CONTROL, 32'h1);
        write_reg(REG_CONTROL, 32'h0);
    endtask

    // hold the beat until tready, taken at the following edge
    task automatic send_sample(input logic [DEST_WIDTH-1:0] dest);
        logic [DATA_WIDTH-1:0] w;
        int n;
        draw_word(w);
        @(posedge S_AXI_clk);
        i_src_tdata  <= w;
        i_src_tdest  <= dest;
        i_src_tvalid <= 1'b1;
        n = 0;
        @(negedge S_AXI_clk);
        while (!o_src_tready && n < 200) begin
            @(negedge S_AXI_clk);
            n++;
        end
        if (!o_src_tready) begin
            $display("stream beat was never accepted, tready stayed low");
            errors++;
        end
        @(posedge S_AXI_clk);
        i_src_tvalid <= 1'b0;
        // only this channel's beats reach memory
        if (dest == MY_DEST) begin
            exp_q.push_back(w[SAMPLE_WIDTH-1:0]);
        end
    endtask

    task automatic wait_load_done();
        logic [31:0] d;
        int n;
        n = 0;
        d = '0;
        while (!d[STAT_LOAD_DONE] && n < 50) begin
            read_reg(REG_STATUS, d);
            n++;
        end
        if (!d[STAT_LOAD_DONE]) begin
            $display("load_done never came up while polling the status register");
            errors++;
        end
    endtask

    // debug read-back of every expected sample
    task automatic verify_mem();
        logic [31:0] d;
        for (int i = 0; i < exp_q.size(); i++) begin
            write_reg(REG_REF_ADDR, i);
            read_reg(REG_REF_DOUT, d);
            check("ref_dout", d, 32'(exp_q[i]));
        end
    endtask

    task automatic test_identity();
        logic [31:0] d;
        logic        inv;
        int          e0;
        e0 = errors;
        read_reg(REG_KEY, d);
        check("key", d, 32'h0ca7_cafe);
        read_reg(REG_VERSION, d);
        check("version", d, 32'h1000_0000);
        write_reg(REG_REF_LEN, 32'h0000_0123);
        read_reg(REG_REF_LEN, d);
        check("ref_len", d, 32'h0000_0123);
        // reserved bits come back as written
        write_reg(REG_CONTROL, 32'h5a5a_a5a4);
        read_reg(REG_CONTROL, d);
        check("control", d, 32'h5a5a_a5a4);
        write_reg(REG_CONTROL, 32'h0);
        reg_access(1'b0, 4'd6, 32'h0, d, inv);
        check("o_reg_invalid", 32'(inv), 32'h1);
        check("o_reg_rdata", d, 32'h0);
        reg_access(1'b1, REG_STATUS, 32'hffff_ffff, d, inv);
        check("o_reg_invalid", 32'(inv), 32'h1);
        finish_test("identity and registers", e0);
    endtask

    task automatic test_reset_state();
        logic [31:0] d;
        int          e0;
        e0 = errors;
        read_reg(REG_STATUS, d);
        check("status", d, 32'h4);
        @(negedge S_AXI_clk);
        check("o_src_tready", 32'(o_src_tready), 32'h1);
        finish_test("reset state", e0);
    endtask

    task automatic test_reference_load();
        logic [31:0] d;
        int          e0;
        e0 = errors;
        exp_q.delete();
        write_reg(REG_REF_LEN, 32'd5);
        // run first, five words do not fit a four deep fifo
        write_reg(REG_CONTROL, 32'h2);
        // busy from the first loading cycle, fifo still empty
        read_reg(REG_STATUS, d);
        check("status", d, 32'h5);
        repeat (5) send_sample(MY_DEST);
        wait_load_done();
        read_reg(REG_STATUS, d);
        check("status", d, 32'h6);
        verify_mem();
        finish_test("reference load", e0);
    endtask

    task automatic test_dest_filter();
        logic [31:0] d;
        int          e0;
        e0 = errors;
        soft_reset();
        exp_q.delete();
        write_reg(REG_REF_LEN, 32'd4);
        write_reg(REG_CONTROL, 32'h2);
        // odd beats go to channels 9, 11, 13, 15
        for (int i = 0; i < 8; i++) begin
            send_sample((i % 2 == 0) ? MY_DEST : DEST_WIDTH'(i + 8));
        end
        wait_load_done();
        read_reg(REG_STATUS, d);
        check("status", d, 32'h6);
        verify_mem();
        finish_test("destination filter", e0);
    endtask

    task automatic test_backpressure();
        logic [31:0] d;
        int          e0;
        e0 = errors;
        soft_reset();
        exp_q.delete();
        write_reg(REG_REF_LEN, 32'd6);
        repeat (4) send_sample(MY_DEST);
        @(negedge S_AXI_clk);
        check("o_src_tready", 32'(o_src_tready), 32'h0);
        read_reg(REG_STATUS, d);
        check("status", d, 32'h8);
        // loader drains, last two beats get in
        write_reg(REG_CONTROL, 32'h2);
        repeat (2) send_sample(MY_DEST);
        wait_load_done();
        verify_mem();
        finish_test("back-pressure", e0);
    endtask

    task automatic test_soft_reset();
        logic [31:0] d;
        int          e0;
        e0 = errors;
        // loader is done, so this word stays in the fifo
        send_sample(MY_DEST);
        read_reg(REG_STATUS, d);
        check("status", d, 32'h2);
        write_reg(REG_CONTROL, 32'h1);
        read_reg(REG_STATUS, d);
        check("status", d, 32'h4);
        write_reg(REG_CONTROL, 32'h0);
        write_reg(REG_REF_LEN, 32'd0);
        write_reg(REG_CONTROL, 32'h2);
        wait_load_done();
        read_reg(REG_STATUS, d);
        check("status", d, 32'h6);
        finish_test("soft reset", e0);
    endtask

    // run limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge S_AXI_clk);
            cycles++;
        end
        $display("run stopped after %0d clock cycles, the tests did not finish", CYCLE_LIMIT);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        w_axi_rst    = 1'b1;
        i_reg_addr   = '0;
        i_reg_wdata  = '0;
        i_reg_wr     = 1'b0;
        i_reg_rd     = 1'b0;
        i_src_tdata  = '0;
        i_src_tdest  = '0;
        i_src_tvalid = 1'b0;
        lfsr_q       = 16'd90;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_bad    = 0;
        repeat (2) @(posedge S_AXI_clk);
        w_axi_rst <= 1'b0;
        test_identity();
        test_reset_state();
        test_reference_load();
        test_dest_filter();
        test_backpressure();
        test_soft_reset();
        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== dtw_accel_top.sv ====
//******************************
// dtw accelerator control shell
// register block, stream filter, fifo, loader
//******************************
`timescale 1ns/100ps

module dtw_accel_top
    import dtw_pkg::*;
#(
    parameter int          FIFO_DEPTH = 4,
    parameter int unsigned CHANNEL_ID = 0
) (
    input  logic                      S_AXI_clk,
    input  logic                      w_axi_rst,
    // register strobe port
    input  logic [REG_ADDR_WIDTH-1:0] i_reg_addr,
    input  logic [DATA_WIDTH-1:0]     i_reg_wdata,
    input  logic                      i_reg_wr,
    input  logic                      i_reg_rd,
    output logic                      o_reg_ack,
    output logic [DATA_WIDTH-1:0]     o_reg_rdata,
    output logic                      o_reg_invalid,
    // sample stream in
    input  logic [DATA_WIDTH-1:0]     i_src_tdata,
    input  logic [DEST_WIDTH-1:0]     i_src_tdest,
    input  logic                      i_src_tvalid,
    output logic                      o_src_tready
);

    logic                  w_fifo_wr_stb;
    logic [DATA_WIDTH-1:0] w_fifo_wr_data;
    logic                  w_fifo_full;

    fifo_rd_if  w_rd_if ();
    ref_ctrl_if w_ctrl_if ();

    stream_filter #(.CHANNEL_ID(CHANNEL_ID)) i_stream_filter (
        .S_AXI_clk (S_AXI_clk),
        .w_axi_rst (w_axi_rst),
        .i_tdata   (i_src_tdata),
        .i_tdest   (i_src_tdest),
        .i_tvalid  (i_src_tvalid),
        .o_tready  (o_src_tready),
        .i_full    (w_fifo_full),
        .o_wr_stb  (w_fifo_wr_stb),
        .o_wr_data (w_fifo_wr_data)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_sample_fifo (
        .S_AXI_clk (S_AXI_clk),
        .w_axi_rst (w_axi_rst),
        .i_wr_stb  (w_fifo_wr_stb),
        .i_wr_data (w_fifo_wr_data),
        .o_full    (w_fifo_full),
        .rd        (w_rd_if.fifo_side)
    );

    ref_loader i_ref_loader (
        .S_AXI_clk (S_AXI_clk),
        .w_axi_rst (w_axi_rst),
        .rd        (w_rd_if.loader_side),
        .ctrl      (w_ctrl_if.loader_side)
    );

    reg_block i_reg_block (
        .S_AXI_clk     (S_AXI_clk),
        .w_axi_rst     (w_axi_rst),
        .i_reg_addr    (i_reg_addr),
        .i_reg_wdata   (i_reg_wdata),
        .i_reg_wr      (i_reg_wr),
        .i_reg_rd      (i_reg_rd),
        .o_reg_ack     (o_reg_ack),
        .o_reg_rdata   (o_reg_rdata),
        .o_reg_invalid (o_reg_invalid),
        .i_fifo_empty  (w_rd_if.empty),
        .i_fifo_full   (w_fifo_full),
        .ctrl          (w_ctrl_if.reg_side)
    );

endmodule

// ==== reg_block.sv ====
//******************************
// dtw register block
// strobe register access, control and status
//******************************
`timescale 1ns/100ps

module reg_block
    import dtw_pkg::*;
(
    input  logic                      S_AXI_clk,
    input  logic                      w_axi_rst,
    input  logic [REG_ADDR_WIDTH-1:0] i_reg_addr,
    input  logic [DATA_WIDTH-1:0]     i_reg_wdata,
    input  logic                      i_reg_wr,
    input  logic                      i_reg_rd,
    output logic                      o_reg_ack,
    output logic [DATA_WIDTH-1:0]     o_reg_rdata,
    output logic                      o_reg_invalid,
    input  logic                      i_fifo_empty,
    input  logic                      i_fifo_full,
    ref_ctrl_if.reg_side              ctrl
);

    control_u                    control_q;
    logic [REFMEM_PTR_WIDTH:0]   ref_len_q;
    logic [REFMEM_PTR_WIDTH-1:0] dbg_addr_q;
    logic [DATA_WIDTH-1:0]       status_word;
    logic [DATA_WIDTH-1:0]       rd_word;
    logic                        rd_known;
    logic                        wr_known;

    // control fields out to the loader
    assign ctrl.soft_rst = control_q.f.soft_rst;
    assign ctrl.run      = control_q.f.run;
    assign ctrl.ref_len  = ref_len_q;
    assign ctrl.dbg_addr = dbg_addr_q;

    // status, unused bits zero
    always_comb begin
        status_word                  = '0;
        status_word[STAT_BUSY]       = ctrl.busy;
        status_word[STAT_LOAD_DONE]  = ctrl.load_done;
        status_word[STAT_FIFO_EMPTY] = i_fifo_empty;
        status_word[STAT_FIFO_FULL]  = i_fifo_full;
    end

    // read mux and address decode
    always_comb begin
        rd_word  = '0;
        rd_known = 1'b1;
        wr_known = 1'b0;
        case (i_reg_addr)
            REG_CONTROL: begin
                rd_word  = control_q.raw;
                wr_known = 1'b1;
            end
            REG_STATUS:  rd_word = status_word;
            REG_REF_LEN: begin
                rd_word  = DATA_WIDTH'(ref_len_q);
                wr_known = 1'b1;
            end
            REG_VERSION: rd_word = VERSION_WORD;
            REG_KEY:     rd_word = KEY_WORD;
            REG_REF_ADDR: begin
                rd_word  = DATA_WIDTH'(dbg_addr_q);
                wr_known = 1'b1;
            end
            REG_REF_DOUT: rd_word = DATA_WIDTH'(ctrl.dbg_dout);
            // unmapped, reads back zero
            default: rd_known = 1'b0;
        endcase
    end

    // read data is payload, no reset
    always_ff @(posedge S_AXI_clk) begin
        if (i_reg_rd) begin
            o_reg_rdata <= rd_word;
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            o_reg_ack     <= 1'b0;
            o_reg_invalid <= 1'b0;
            control_q.raw <= '0;
            ref_len_q     <= '0;
            dbg_addr_q    <= '0;
        end else begin
            // ack and invalid are single-cycle strobes
            o_reg_ack     <= i_reg_wr | i_reg_rd;
            o_reg_invalid <= (i_reg_wr & ~wr_known) | (i_reg_rd & ~rd_known);
            if (i_reg_wr) begin
                case (i_reg_addr)
                    REG_CONTROL:  control_q.raw <= i_reg_wdata;
                    REG_REF_LEN:  ref_len_q     <= i_reg_wdata[REFMEM_PTR_WIDTH:0];
                    REG_REF_ADDR: dbg_addr_q    <= i_reg_wdata[REFMEM_PTR_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    // host issues one request at a time
    assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        i_reg_wr |-> !i_reg_rd)
        else $error("reg_block: read and write in the same cycle");

endmodule

// ==== ref_loader.sv ====
//******************************
// reference loader
// fills reference memory from the fifo
//******************************
`timescale 1ns/100ps

module ref_loader
    import dtw_pkg::*;
(
    input  logic            S_AXI_clk,
    input  logic            w_axi_rst,
    fifo_rd_if.loader_side  rd,
    ref_ctrl_if.loader_side ctrl
);

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_LOAD = 1'b1;

    logic [SAMPLE_WIDTH-1:0]     ref_mem [2**REFMEM_PTR_WIDTH];
    logic                        state_q;
    logic [REFMEM_PTR_WIDTH-1:0] wr_ptr_q;
    logic [REFMEM_PTR_WIDTH:0]   cnt_q;
    logic                        load_done_q;
    logic                        go;
    logic                        len_reached;
    logic                        pop;

    // run set, not in soft reset, not finished yet
    assign go          = ctrl.run & ~ctrl.soft_rst & ~load_done_q;
    assign len_reached = (cnt_q >= ctrl.ref_len);
    // one word per cycle, stalls on empty fifo
    assign pop = (state_q == ST_LOAD) & go & ~rd.empty & ~len_reached;

    assign rd.rd_stb      = pop;
    assign rd.clear       = ctrl.soft_rst;
    assign ctrl.busy      = (state_q == ST_LOAD);
    assign ctrl.load_done = load_done_q;
    // debug read-back, asynchronous
    assign ctrl.dbg_dout  = ref_mem[ctrl.dbg_addr];

    // sample is the low half of the fifo word
    always_ff @(posedge S_AXI_clk) begin
        if (pop) begin
            ref_mem[wr_ptr_q] <= rd.data[SAMPLE_WIDTH-1:0];
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || ctrl.soft_rst) begin
            state_q     <= ST_IDLE;
            wr_ptr_q    <= '0;
            cnt_q       <= '0;
            load_done_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // zero length finishes straight away
                    if (go && len_reached) begin
                        load_done_q <= 1'b1;
                    end else if (go) begin
                        state_q <= ST_LOAD;
                    end
                end
                default: begin
                    if (pop) begin
                        wr_ptr_q <= wr_ptr_q + 1'b1;
                        cnt_q    <= cnt_q + 1'b1;
                    end
                    // run low just pauses, pointer held
                    if (go && len_reached) begin
                        load_done_q <= 1'b1;
                        state_q     <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // every write lands inside the reference memory
    assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        pop |-> (cnt_q < (REFMEM_PTR_WIDTH+1)'(2**REFMEM_PTR_WIDTH)))
        else $error("ref_loader: write past the end of reference memory");

endmodule

// ==== sample_fifo.sv ====
//******************************
// source sample fifo
// first-word-fall-through ring buffer with clear
//******************************
`timescale 1ns/100ps

module sample_fifo
    import dtw_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  S_AXI_clk,
    input  logic                  w_axi_rst,
    input  logic                  i_wr_stb,
    input  logic [DATA_WIDTH-1:0] i_wr_data,
    output logic                  o_full,
    fifo_rd_if.fifo_side          rd
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [PTR_W:0]        count_q;
    logic                  push;
    logic                  pop;

    assign o_full   = (count_q == (PTR_W+1)'(FIFO_DEPTH));
    assign rd.empty = (count_q == '0);
    // head word always on the read port
    assign rd.data  = mem[rd_ptr_q];

    assign push = i_wr_stb & ~o_full;
    assign pop  = rd.rd_stb & ~rd.empty;

    // storage, no reset
    always_ff @(posedge S_AXI_clk) begin
        if (push) begin
            mem[wr_ptr_q] <= i_wr_data;
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || rd.clear) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // pointers wrap, depth is a power of two
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // push and pop together leave the count alone
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // loader may only pop a word that is there
    assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        rd.rd_stb |-> !rd.empty)
        else $error("sample_fifo: pop while empty");

endmodule

// ==== stream_filter.sv ====
//******************************
// stream destination filter
// forwards this channel's beats into the fifo
//******************************
`timescale 1ns/100ps

module stream_filter
    import dtw_pkg::*;
#(
    parameter int unsigned CHANNEL_ID = 0
) (
    input  logic                  S_AXI_clk,
    input  logic                  w_axi_rst,
    input  logic [DATA_WIDTH-1:0] i_tdata,
    input  logic [DEST_WIDTH-1:0] i_tdest,
    input  logic                  i_tvalid,
    output logic                  o_tready,
    input  logic                  i_full,
    output logic                  o_wr_stb,
    output logic [DATA_WIDTH-1:0] o_wr_data
);

    logic beat_taken;
    logic dest_match;

    // stall the stream only on a full fifo
    assign o_tready   = ~i_full;
    assign beat_taken = i_tvalid & o_tready;

    // other channels' beats are taken and dropped
    assign dest_match = (i_tdest == DEST_WIDTH'(CHANNEL_ID));
    assign o_wr_stb   = beat_taken & dest_match;
    assign o_wr_data  = i_tdata;

    // source holds a stalled beat unchanged until it is taken
    assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        $past(i_tvalid & ~o_tready)
            |-> (i_tvalid && $stable(i_tdata) && $stable(i_tdest)))
        else $error("stream_filter: stalled beat changed or dropped");

endmodule

// ==== dtw_ifs.sv ====
//******************************
// dtw accelerator interfaces
// fifo read port and loader control bundle
//******************************
`timescale 1ns/100ps

// fifo head and pop/clear from the loader
interface fifo_rd_if
    import dtw_pkg::*;
();
    logic                  rd_stb;
    logic                  clear;
    logic [DATA_WIDTH-1:0] data;
    logic                  empty;

    modport fifo_side   (input rd_stb, input clear, output data, output empty);
    modport loader_side (output rd_stb, output clear, input data, input empty);
endinterface

// register block to loader, status back
interface ref_ctrl_if
    import dtw_pkg::*;
();
    logic                        soft_rst;
    logic                        run;
    logic [REFMEM_PTR_WIDTH:0]   ref_len;
    logic [REFMEM_PTR_WIDTH-1:0] dbg_addr;
    logic                        busy;
    logic                        load_done;
    logic [SAMPLE_WIDTH-1:0]     dbg_dout;

    modport reg_side (
        output soft_rst, output run, output ref_len, output dbg_addr,
        input  busy, input load_done, input dbg_dout
    );
    modport loader_side (
        input  soft_rst, input run, input ref_len, input dbg_addr,
        output busy, output load_done, output dbg_dout
    );
endinterface

// ==== dtw_pkg.sv ====
//******************************
// dtw accelerator shared package
// widths, register map, id words and control word
//******************************
package dtw_pkg;

    // register and stream word
    localparam int DATA_WIDTH       = 32;
    // reference sample, low half of a stream word
    localparam int SAMPLE_WIDTH     = 16;
    // 256 entry reference memory
    localparam int REFMEM_PTR_WIDTH = 8;
    localparam int DEST_WIDTH       = 4;
    localparam int REG_ADDR_WIDTH   = 4;

    // register map
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CONTROL  = 4'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_STATUS   = 4'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_REF_LEN  = 4'd2;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_VERSION  = 4'd3;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_KEY      = 4'd4;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_REF_ADDR = 4'd5;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_REF_DOUT = 4'd7;

    // major 1, minor 0, revision 0
    localparam logic [DATA_WIDTH-1:0] VERSION_WORD = 32'h1000_0000;
    localparam logic [DATA_WIDTH-1:0] KEY_WORD     = 32'h0ca7_cafe;

    // status word bit positions
    localparam int STAT_BUSY       = 0;
    localparam int STAT_LOAD_DONE  = 1;
    localparam int STAT_FIFO_EMPTY = 2;
    localparam int STAT_FIFO_FULL  = 3;

    // control word, raw for the bus, fields for the loader
    typedef union packed {
        logic [DATA_WIDTH-1:0] raw;
        struct packed {
            logic [DATA_WIDTH-3:0] rsvd;
            logic                  run;
            logic                  soft_rst;
        } f;
    } control_u;

endpackage
